//--- files.f
source/rv32_pkg.sv
source/inst_fetch.sv
source/inst_queue.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_commit.sv
source/core_top.sv
tb/tb_imem.sv
tb/tb_core_top.sv

//--- Bender.yml
package:
  name: rv32_inorder_core

sources:
  - files:
      - source/rv32_pkg.sv
      - source/inst_fetch.sv
      - source/inst_queue.sv
      - source/inst_decode.sv
      - source/reg_file.sv
      - source/exec_commit.sv
      - source/core_top.sv
  - target: test
    files:
      - tb/tb_imem.sv
      - tb/tb_core_top.sv

//--- tb/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top;

    localparam int N_INST      = 200;
    localparam int PERIOD      = 8;
    localparam int WATCHDOG_NS = N_INST * 6 * PERIOD + 1000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic        commit_valid;
    logic [63:0] commit_order;
    logic [31:0] commit_pc;
    logic [31:0] commit_inst;
    logic [4:0]  commit_rd_addr;
    logic [31:0] commit_rd_wdata;

    integer      seed = 32'h6c02_5016;
    logic [31:0] prog     [N_INST];
    logic [31:0] model_rf [32];
    int          n_commits = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    bit          stream_done = 1'b0;

    initial begin
        forever #(PERIOD / 2) clk = ~clk;
    end

    core_top u_core_top (
        .clk               (clk),
        .rst               (rst),
        .wb_cyc_o          (wb_cyc),
        .wb_stb_o          (wb_stb),
        .wb_adr_o          (wb_adr),
        .wb_dat_i          (wb_dat),
        .wb_ack_i          (wb_ack),
        .commit_valid_o    (commit_valid),
        .commit_order_o    (commit_order),
        .commit_pc_o       (commit_pc),
        .commit_inst_o     (commit_inst),
        .commit_rd_addr_o  (commit_rd_addr),
        .commit_rd_wdata_o (commit_rd_wdata)
    );

    tb_imem #(.DEPTH(N_INST), .SEED(32'h6c02_5016)) u_imem (
        .clk   (clk),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .adr_i (wb_adr),
        .dat_o (wb_dat),
        .ack_o (wb_ack)
    );

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // mostly x1 to x4 so neighbours depend on each other
    function automatic logic [4:0] pick_reg();
        integer r;
        r = $random(seed);
        if (r[2:0] < 3'd6) begin
            return 5'd1 + {3'b0, r[4:3]};
        end
        return r[9:5];
    endfunction

    function automatic logic [31:0] make_inst();
        integer      r;
        integer      v;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [31:0] inst;
        r   = $random(seed);
        v   = $random(seed);
        f3  = r[10:8];
        imm = v[11:0];
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        alt = r[12] && (f3 == 3'b000 || f3 == 3'b101);
        // shift immediates carry only shamt and the arithmetic bit
        if (f3 == 3'b001) begin
            imm[11:5] = 7'b0;
        end
        if (f3 == 3'b101) begin
            imm[11:5] = {1'b0, r[11], 5'b0};
        end
        inst = {imm, rs1, f3, rd, rv32_pkg::OP_IMM};
        case (r[3:0])
            4'd6, 4'd7, 4'd8, 4'd9: inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv32_pkg::OP};
            4'd10: inst = {v[31:12], rd, rv32_pkg::LUI};
            4'd11: inst = {v[31:12], rd, rv32_pkg::AUIPC};
            // multiply group, not supported
            4'd12: inst = {7'b0000001, rs2, rs1, f3, rd, rv32_pkg::OP};
            4'd13: inst = {v[31:7], r[13] ? 7'b0000011 : 7'b1100011};
            4'd14, 4'd15: inst[11:7] = 5'd0;
            default: ;
        endcase
        return inst;
    endfunction

    // alt selects sub for f3 000 and arithmetic shift for f3 101
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b010:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return (a >> sh) | ({32{alt & a[31]}} & ~(32'hffff_ffff >> sh));
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void ref_model(input logic [31:0] inst, input logic [31:0] pc,
                                      output logic [4:0] rd, output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_u;
        logic [2:0]  f3;
        logic [6:0]  f7;
        a     = model_rf[inst[19:15]];
        b     = model_rf[inst[24:20]];
        imm_u = {inst[31:12], 12'b0};
        f3    = inst[14:12];
        f7    = inst[31:25];
        rd    = inst[11:7];
        data  = '0;
        case (inst[6:0])
            rv32_pkg::OP_IMM: begin
                data = alu_ref(f3, f3 == 3'b101 && inst[30], a, {{20{inst[31]}}, inst[31:20]});
            end
            rv32_pkg::OP: begin
                if (f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101))) begin
                    data = alu_ref(f3, inst[30], a, b);
                end else begin
                    rd = '0;
                end
            end
            rv32_pkg::LUI:   data = imm_u;
            rv32_pkg::AUIPC: data = pc + imm_u;
            default:         rd = '0;
        endcase
        if (rd == '0) begin
            data = '0;
        end
        model_rf[rd] = data;
    endfunction

    initial begin : compare
        logic [31:0] exp_pc;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        int          errors_before;
        errors_before = n_errors;
        while (n_commits < N_INST) begin
            @(negedge clk);
            if (commit_valid) begin
                exp_pc = rv32_pkg::RESET_PC + 32'(4 * n_commits);
                ref_model(prog[n_commits], exp_pc, exp_rd, exp_data);
                check($sformatf("commit %0d order", n_commits), commit_order, 64'(n_commits));
                check($sformatf("commit %0d pc", n_commits), commit_pc, exp_pc);
                check($sformatf("commit %0d inst", n_commits), commit_inst, prog[n_commits]);
                check($sformatf("commit %0d rd", n_commits), commit_rd_addr, exp_rd);
                check($sformatf("commit %0d data", n_commits), commit_rd_wdata, exp_data);
                n_commits++;
            end
        end
        $display("test commit_stream: %0d commits, %0d errors", n_commits,
                 n_errors - errors_before);
        stream_done = 1'b1;
    end

    initial begin
        int errors_before;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        for (int i = 0; i < N_INST; i++) begin
            prog[i] = make_inst();
            u_imem.mem[i] = prog[i];
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        wait (stream_done);
        // last commit lands in the register file on the next edge
        repeat (2) @(negedge clk);
        errors_before = n_errors;
        for (int i = 1; i < 32; i++) begin
            check($sformatf("register x%0d", i), u_core_top.u_reg_file.regs[i], model_rf[i]);
        end
        $display("test reg_state: 31 registers, %0d errors", n_errors - errors_before);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: commits stopped arriving after %0d of %0d", n_commits, N_INST);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- tb/tb_imem.sv
`timescale 1ns/1ps

module tb_imem #(
    parameter int     DEPTH = 200,
    parameter integer SEED  = 32'h6c02_5016
) (
    input  logic        clk,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic [31:0] adr_i,
    output logic [31:0] dat_o,
    output logic        ack_o
);

    logic [31:0] mem [DEPTH];
    integer      seed = SEED;
    integer      wait_left = 0;
    logic        pending = 1'b0;
    logic        ack_q = 1'b0;
    logic [31:0] dat_q = '0;

    assign ack_o = ack_q;
    assign dat_o = dat_q;

    // past the program the fill is a system opcode, which retires as a no-op
    function automatic logic [31:0] read_word(input logic [31:0] adr);
        logic [31:0] idx;
        idx = (adr - rv32_pkg::RESET_PC) >> 2;
        if (idx < DEPTH) begin
            return mem[idx];
        end
        return {adr[31:7] ^ adr[24:0], 7'b1110011};
    endfunction

    // classic slave, ack for one cycle after 0 to 3 wait cycles
    always @(negedge clk) begin
        ack_q <= 1'b0;
        if (cyc_i && stb_i) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                pending = 1'b0;
                dat_q <= read_word(adr_i);
                ack_q <= 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

endmodule

//--- source/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                            clk,
    input  logic                            rst,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic [rv32_pkg::XLEN-1:0]       wb_adr_o,
    input  logic [rv32_pkg::XLEN-1:0]       wb_dat_i,
    input  logic                            wb_ack_i,
    output logic                            commit_valid_o,
    output logic [rv32_pkg::ORDER_W-1:0]    commit_order_o,
    output logic [rv32_pkg::XLEN-1:0]       commit_pc_o,
    output logic [rv32_pkg::XLEN-1:0]       commit_inst_o,
    output logic [rv32_pkg::REG_ADDR_W-1:0] commit_rd_addr_o,
    output logic [rv32_pkg::XLEN-1:0]       commit_rd_wdata_o
);

    logic                            full;
    logic                            empty;
    logic                            issue;
    logic                            enq;
    logic [rv32_pkg::XLEN-1:0]       enq_inst;
    logic [rv32_pkg::XLEN-1:0]       enq_pc;
    logic [rv32_pkg::ORDER_W-1:0]    enq_order;
    logic [rv32_pkg::XLEN-1:0]       head_inst;
    logic [rv32_pkg::XLEN-1:0]       head_pc;
    logic [rv32_pkg::ORDER_W-1:0]    head_order;
    logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv32_pkg::REG_ADDR_W-1:0] rd_addr;
    rv32_pkg::alu_op_e               alu_op;
    logic                            use_imm;
    logic                            src_a_pc;
    logic [rv32_pkg::XLEN-1:0]       imm;
    logic [rv32_pkg::XLEN-1:0]       rs1_data;
    logic [rv32_pkg::XLEN-1:0]       rs2_data;
    logic                            rf_we;
    logic [rv32_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [rv32_pkg::XLEN-1:0]       rf_wdata;

    // issue every cycle the queue has a head
    assign issue = ~empty;

    inst_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .full_i      (full),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .enq_o       (enq),
        .enq_inst_o  (enq_inst),
        .enq_pc_o    (enq_pc),
        .enq_order_o (enq_order)
    );

    inst_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .enq_i        (enq),
        .enq_inst_i   (enq_inst),
        .enq_pc_i     (enq_pc),
        .enq_order_i  (enq_order),
        .full_o       (full),
        .deq_i        (issue),
        .head_inst_o  (head_inst),
        .head_pc_o    (head_pc),
        .head_order_o (head_order),
        .empty_o      (empty)
    );

    inst_decode u_decode (
        .inst_i     (head_inst),
        .pc_i       (head_pc),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .alu_op_o   (alu_op),
        .use_imm_o  (use_imm),
        .src_a_pc_o (src_a_pc),
        .imm_o      (imm)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    exec_commit u_exec (
        .clk               (clk),
        .rst               (rst),
        .issue_i           (issue),
        .inst_i            (head_inst),
        .pc_i              (head_pc),
        .order_i           (head_order),
        .rs1_addr_i        (rs1_addr),
        .rs2_addr_i        (rs2_addr),
        .rd_addr_i         (rd_addr),
        .alu_op_i          (alu_op),
        .use_imm_i         (use_imm),
        .src_a_pc_i        (src_a_pc),
        .imm_i             (imm),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .rf_we_o           (rf_we),
        .rf_waddr_o        (rf_waddr),
        .rf_wdata_o        (rf_wdata),
        .commit_valid_o    (commit_valid_o),
        .commit_order_o    (commit_order_o),
        .commit_pc_o       (commit_pc_o),
        .commit_inst_o     (commit_inst_o),
        .commit_rd_addr_o  (commit_rd_addr_o),
        .commit_rd_wdata_o (commit_rd_wdata_o)
    );

endmodule

//--- source/exec_commit.sv
`timescale 1ns/1ps

module exec_commit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            issue_i,
    input  logic [rv32_pkg::XLEN-1:0]       inst_i,
    input  logic [rv32_pkg::XLEN-1:0]       pc_i,
    input  logic [rv32_pkg::ORDER_W-1:0]    order_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  rv32_pkg::alu_op_e               alu_op_i,
    input  logic                            use_imm_i,
    input  logic                            src_a_pc_i,
    input  logic [rv32_pkg::XLEN-1:0]       imm_i,
    input  logic [rv32_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv32_pkg::XLEN-1:0]       rs2_data_i,
    output logic                            rf_we_o,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [rv32_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                            commit_valid_o,
    output logic [rv32_pkg::ORDER_W-1:0]    commit_order_o,
    output logic [rv32_pkg::XLEN-1:0]       commit_pc_o,
    output logic [rv32_pkg::XLEN-1:0]       commit_inst_o,
    output logic [rv32_pkg::REG_ADDR_W-1:0] commit_rd_addr_o,
    output logic [rv32_pkg::XLEN-1:0]       commit_rd_wdata_o
);

    logic                      fwd_a;
    logic                      fwd_b;
    logic [rv32_pkg::XLEN-1:0] rs1_val;
    logic [rv32_pkg::XLEN-1:0] rs2_val;
    logic [rv32_pkg::XLEN-1:0] op_a;
    logic [rv32_pkg::XLEN-1:0] op_b;
    logic [rv32_pkg::XLEN-1:0] result;

    // commit register is written to the file at the end of this cycle
    assign fwd_a = rf_we_o && (commit_rd_addr_o == rs1_addr_i);
    assign fwd_b = rf_we_o && (commit_rd_addr_o == rs2_addr_i);

    assign rs1_val = fwd_a ? commit_rd_wdata_o : rs1_data_i;
    assign rs2_val = fwd_b ? commit_rd_wdata_o : rs2_data_i;
    assign op_a    = src_a_pc_i ? pc_i : rs1_val;
    assign op_b    = use_imm_i ? imm_i : rs2_val;

    always_comb begin
        case (alu_op_i)
            rv32_pkg::ALU_ADD:    result = op_a + op_b;
            rv32_pkg::ALU_SUB:    result = op_a - op_b;
            rv32_pkg::ALU_SLL:    result = op_a << op_b[4:0];
            rv32_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv32_pkg::ALU_SLTU:   result = {31'b0, op_a < op_b};
            rv32_pkg::ALU_XOR:    result = op_a ^ op_b;
            rv32_pkg::ALU_SRL:    result = op_a >> op_b[4:0];
            rv32_pkg::ALU_SRA:    result = $unsigned($signed(op_a) >>> op_b[4:0]);
            rv32_pkg::ALU_OR:     result = op_a | op_b;
            rv32_pkg::ALU_AND:    result = op_a & op_b;
            rv32_pkg::ALU_PASS_B: result = op_b;
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            commit_order_o   <= order_i;
            commit_pc_o      <= pc_i;
            commit_inst_o    <= inst_i;
            commit_rd_addr_o <= rd_addr_i;
            // x0 destinations report zero data
            commit_rd_wdata_o <= (rd_addr_i == '0) ? '0 : result;
        end
    end

    assign rf_we_o    = commit_valid_o && (commit_rd_addr_o != '0);
    assign rf_waddr_o = commit_rd_addr_o;
    assign rf_wdata_o = commit_rd_wdata_o;

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv32_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv32_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                            we_i,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv32_pkg::XLEN-1:0]       wdata_i
);

    // x0 has no storage
    logic [rv32_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- source/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic [rv32_pkg::XLEN-1:0]       inst_i,
    input  logic [rv32_pkg::XLEN-1:0]       pc_i,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [rv32_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output rv32_pkg::alu_op_e               alu_op_o,
    output logic                            use_imm_o,
    output logic                            src_a_pc_o,
    output logic [rv32_pkg::XLEN-1:0]       imm_o
);

    rv32_pkg::opcode_e         opcode;
    rv32_pkg::alu_op_e         funct_op;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic                      aligned;
    logic [rv32_pkg::XLEN-1:0] imm_i_type;
    logic [rv32_pkg::XLEN-1:0] imm_u_type;

    assign opcode     = rv32_pkg::opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    // misaligned fetch retires as a no-op
    assign aligned    = (pc_i[1:0] == 2'b00);

    // funct3 mapping shared by op and op-imm
    always_comb begin
        case (funct3)
            3'b000:  funct_op = rv32_pkg::ALU_ADD;
            3'b001:  funct_op = rv32_pkg::ALU_SLL;
            3'b010:  funct_op = rv32_pkg::ALU_SLT;
            3'b011:  funct_op = rv32_pkg::ALU_SLTU;
            3'b100:  funct_op = rv32_pkg::ALU_XOR;
            3'b101:  funct_op = inst_i[30] ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
            3'b110:  funct_op = rv32_pkg::ALU_OR;
            default: funct_op = rv32_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        rd_addr_o  = '0;
        alu_op_o   = rv32_pkg::ALU_ADD;
        use_imm_o  = 1'b0;
        src_a_pc_o = 1'b0;
        imm_o      = imm_i_type;
        if (aligned) begin
            case (opcode)
                rv32_pkg::OP_IMM: begin
                    rd_addr_o = inst_i[11:7];
                    alu_op_o  = funct_op;
                    use_imm_o = 1'b1;
                end
                rv32_pkg::OP: begin
                    // funct7 of 0000001 is multiply, not handled
                    if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                        rd_addr_o = inst_i[11:7];
                        if (funct3 == 3'b000 && inst_i[30]) begin
                            alu_op_o = rv32_pkg::ALU_SUB;
                        end else begin
                            alu_op_o = funct_op;
                        end
                    end
                end
                rv32_pkg::LUI: begin
                    rd_addr_o = inst_i[11:7];
                    alu_op_o  = rv32_pkg::ALU_PASS_B;
                    use_imm_o = 1'b1;
                    imm_o     = imm_u_type;
                end
                rv32_pkg::AUIPC: begin
                    rd_addr_o  = inst_i[11:7];
                    use_imm_o  = 1'b1;
                    src_a_pc_o = 1'b1;
                    imm_o      = imm_u_type;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int DEPTH = rv32_pkg::QUEUE_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         enq_i,
    input  logic [rv32_pkg::XLEN-1:0]    enq_inst_i,
    input  logic [rv32_pkg::XLEN-1:0]    enq_pc_i,
    input  logic [rv32_pkg::ORDER_W-1:0] enq_order_i,
    output logic                         full_o,
    input  logic                         deq_i,
    output logic [rv32_pkg::XLEN-1:0]    head_inst_o,
    output logic [rv32_pkg::XLEN-1:0]    head_pc_o,
    output logic [rv32_pkg::ORDER_W-1:0] head_order_o,
    output logic                         empty_o
);

    logic [rv32_pkg::XLEN-1:0]    inst_mem  [DEPTH];
    logic [rv32_pkg::XLEN-1:0]    pc_mem    [DEPTH];
    logic [rv32_pkg::ORDER_W-1:0] order_mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH):0]       count;
    logic                         do_enq;
    logic                         do_deq;

    assign full_o  = (count == DEPTH);
    assign empty_o = (count == '0);
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o;

    assign head_inst_o  = inst_mem[rd_ptr];
    assign head_pc_o    = pc_mem[rd_ptr];
    assign head_order_o = order_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_enq) begin
            inst_mem[wr_ptr]  <= enq_inst_i;
            pc_mem[wr_ptr]    <= enq_pc_i;
            order_mem[wr_ptr] <= enq_order_i;
        end
    end

    // pointers wrap naturally at power-of-two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         full_i,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic [rv32_pkg::XLEN-1:0]    wb_adr_o,
    input  logic [rv32_pkg::XLEN-1:0]    wb_dat_i,
    input  logic                         wb_ack_i,
    output logic                         enq_o,
    output logic [rv32_pkg::XLEN-1:0]    enq_inst_o,
    output logic [rv32_pkg::XLEN-1:0]    enq_pc_o,
    output logic [rv32_pkg::ORDER_W-1:0] enq_order_o
);

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_e;

    fetch_state_e                 state;
    logic [rv32_pkg::XLEN-1:0]    pc;
    logic [rv32_pkg::ORDER_W-1:0] order;
    logic                         word_done;

    // cyc and stb stay up with a stable address until ack
    assign wb_cyc_o  = (state == FETCH_WAIT);
    assign wb_stb_o  = (state == FETCH_WAIT);
    assign wb_adr_o  = pc;
    assign word_done = (state == FETCH_WAIT) && wb_ack_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_IDLE;
            pc    <= rv32_pkg::RESET_PC;
            order <= '0;
            enq_o <= 1'b0;
        end else begin
            enq_o <= word_done;
            case (state)
                FETCH_IDLE: begin
                    // one request in flight, so room is checked only here
                    if (!full_i) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (wb_ack_i) begin
                        state <= FETCH_IDLE;
                        pc    <= pc + 32'd4;
                        order <= order + 1'b1;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // word tagged with the pc and order it was fetched under
    always_ff @(posedge clk) begin
        if (word_done) begin
            enq_inst_o  <= wb_dat_i;
            enq_pc_o    <= pc;
            enq_order_o <= order;
        end
    end

endmodule

//--- source/rv32_pkg.sv
package rv32_pkg;

    localparam int XLEN        = 32;
    localparam int ORDER_W     = 64;
    localparam int REG_ADDR_W  = 5;
    localparam int QUEUE_DEPTH = 8;

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'haaaaa000;

    // major opcodes handled here, anything else retires as a no-op
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // lui result is just the immediate
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage
